// File: source/tilemapPkg.sv
package tilemapPkg;

	//////////////////////////////
	// Bus and address widths
	//////////////////////////////

	// CPU address bus
	typedef logic [13:0] cpuAddrT;
	// One byte on the CPU or tile RAM data bus
	typedef logic [7:0] byteT;
	// Tile RAM address at the pins, layer bit on top
	typedef logic [12:0] ramAddrT;
	// Per-layer tile RAM address, 6-bit row then 6-bit column
	typedef logic [11:0] layerRamAddrT;
	// Graphics ROM address, tile code then fine row then fine column
	typedef logic [13:0] romAddrT;

	// Scroll values, one pixel per step
	typedef logic [8:0] scrollXT;
	typedef logic [7:0] scrollYT;

	// Beam position counters
	typedef logic [8:0] hPosT;
	typedef logic [7:0] vPosT;

	//////////////////////////////
	// Scroll register map
	//////////////////////////////

	typedef logic [1:0] regSelT;

	// X low byte, X bit 8, Y; index 3 has no register
	localparam regSelT regXLo = 2'd0;
	localparam regSelT regXHi = 2'd1;
	localparam regSelT regY = 2'd2;

	// One register write, already split per layer
	typedef struct packed {
		logic strobe;
		regSelT sel;
		byteT data;
	} regWriteT;

	// Address set produced by one layer
	typedef struct packed {
		layerRamAddrT ram;
		romAddrT rom;
		logic half;
	} layerAddrT;

endpackage

// File: source/scrollLayer.sv
module scrollLayer #(
	parameter bit autoScroll = 1'b0
) (
	input logic CLK_6M,
	input logic rstN,
	input logic hSyncN,
	input logic vSyncN,
	input logic flip,
	// High during this layer's tile RAM fetch phase
	input logic fetchSlot,
	input logic ramCsN,
	input tilemapPkg::regWriteT regWrite,
	input tilemapPkg::byteT ramData,
	output tilemapPkg::layerAddrT addr
);

	// Scroll registers
	tilemapPkg::scrollXT scrollX;
	tilemapPkg::scrollYT scrollY;

	// Beam position
	tilemapPkg::hPosT colCount;
	tilemapPkg::vPosT lineCount;

	// Sync history for edge detection
	logic hSyncPrev;
	logic vSyncPrev;
	logic hSyncFall;
	logic vSyncFall;

	// Tile code fetched from tile RAM
	tilemapPkg::byteT tileCode;

	// Per-register write strobes
	logic writeXLo;
	logic writeXHi;
	logic writeY;

	// Scrolled and flipped position
	tilemapPkg::hPosT colSum;
	tilemapPkg::vPosT lineSum;
	tilemapPkg::hPosT scrolledCol;
	tilemapPkg::vPosT scrolledLine;

	//////////////////////////////
	// CPU scroll registers
	//////////////////////////////

	assign writeXLo = regWrite.strobe && (regWrite.sel == tilemapPkg::regXLo);
	assign writeXHi = regWrite.strobe && (regWrite.sel == tilemapPkg::regXHi);
	assign writeY = regWrite.strobe && (regWrite.sel == tilemapPkg::regY);

	always_ff @(posedge CLK_6M or negedge rstN) begin
		if (!rstN) begin
			scrollX <= '0;
			scrollY <= '0;
		end else begin
			if (writeY) begin
				scrollY <= regWrite.data;
			end
			// CPU write beats autoscroll in the same cycle
			if (writeXLo) begin
				scrollX[7:0] <= regWrite.data;
			end else if (writeXHi) begin
				scrollX[8] <= regWrite.data[0];
			end else if (autoScroll && vSyncFall) begin
				// One pixel per frame
				scrollX <= scrollX + 9'd1;
			end
		end
	end

	//////////////////////////////
	// Beam counters
	//////////////////////////////

	// Falling edges of the active-low syncs
	assign hSyncFall = hSyncPrev && !hSyncN;
	assign vSyncFall = vSyncPrev && !vSyncN;

	always_ff @(posedge CLK_6M or negedge rstN) begin
		if (!rstN) begin
			// Syncs idle high
			hSyncPrev <= 1'b1;
			vSyncPrev <= 1'b1;
			colCount <= '0;
			lineCount <= '0;
		end else begin
			hSyncPrev <= hSyncN;
			vSyncPrev <= vSyncN;
			// Column restarts every line
			if (!hSyncN) begin
				colCount <= '0;
			end else begin
				colCount <= colCount + 9'd1;
			end
			// Vertical sync wins over the line step
			if (!vSyncN) begin
				lineCount <= '0;
			end else if (hSyncFall) begin
				lineCount <= lineCount + 8'd1;
			end
		end
	end

	//////////////////////////////
	// Tile code latch
	//////////////////////////////

	// Skipped when the CPU holds the RAM bus
	always_ff @(posedge CLK_6M or negedge rstN) begin
		if (!rstN) begin
			tileCode <= '0;
		end else if (fetchSlot && ramCsN) begin
			tileCode <= ramData;
		end
	end

	//////////////////////////////
	// Address forming
	//////////////////////////////

	// Wraps at 512 columns and 256 lines
	assign colSum = colCount + scrollX;
	assign lineSum = lineCount + scrollY;

	// Screen flip mirrors both axes
	assign scrolledCol = flip ? ~colSum : colSum;
	assign scrolledLine = flip ? ~lineSum : lineSum;

	always_comb begin
		// 32 tile rows used of 64, top bit held low
		addr.ram = {1'b0, scrolledLine[7:3], scrolledCol[8:3]};
		// Fine position inside the 8x8 tile
		addr.rom = {tileCode, scrolledLine[2:0], scrolledCol[2:0]};
		addr.half = scrolledCol[2];
	end

endmodule

// File: source/cpuRamPort.sv
module cpuRamPort (
	input logic CLK_6M,
	input logic rstN,
	input logic clk2H,
	input logic ramCsN,
	input logic readNotWrite,
	input tilemapPkg::cpuAddrT cpuAddr,
	input tilemapPkg::byteT cpuDataIn,
	input tilemapPkg::byteT ramDataIn,
	input tilemapPkg::layerAddrT layerA,
	input tilemapPkg::layerAddrT layerB,
	output tilemapPkg::ramAddrT ramAddr,
	output tilemapPkg::romAddrT romAddr,
	output logic ramWeN,
	output logic ramOeN,
	output tilemapPkg::byteT cpuDataOut,
	output tilemapPkg::byteT ramDataOut
);

	// Previous cycle was a read or idle
	logic rnwPrev;

	// Selected layer on the tile RAM bus
	tilemapPkg::layerRamAddrT layerRamAddr;

	//////////////////////////////
	// Write strobe shaping
	//////////////////////////////

	always_ff @(posedge CLK_6M or negedge rstN) begin
		if (!rstN) begin
			rnwPrev <= 1'b0;
		end else begin
			rnwPrev <= readNotWrite;
		end
	end

	// Write pulse only on the first cycle of a write
	assign ramWeN = !(!ramCsN && !readNotWrite && rnwPrev);
	assign ramOeN = !(!ramCsN && readNotWrite);

	//////////////////////////////
	// Address multiplexing
	//////////////////////////////

	// Layer B fetches while clk2H is low
	assign layerRamAddr = clk2H ? layerA.ram : layerB.ram;

	// CPU takes the RAM bus, the layer fetch is lost
	assign ramAddr = !ramCsN ? cpuAddr[12:0] : {~clk2H, layerRamAddr};

	// ROM slot runs opposite to the RAM slot
	assign romAddr = clk2H ? layerB.rom : layerA.rom;

	// Data paths in both directions
	assign ramDataOut = cpuDataIn;
	assign cpuDataOut = ramDataIn;

endmodule

// File: source/tilemapAddrGen.sv
module tilemapAddrGen #(
	parameter bit autoScrollA = 1'b0,
	parameter bit autoScrollB = 1'b0
) (
	// Clock, reset and video timing
	input logic CLK_6M,
	input logic rstN,
	input logic clk2H,
	input logic hSyncN,
	input logic vSyncN,
	input logic flip,
	// CPU side
	input logic latchN,
	input logic ramCsN,
	input tilemapPkg::cpuAddrT cpuAddr,
	input logic readNotWrite,
	input tilemapPkg::byteT cpuDataIn,
	output tilemapPkg::byteT cpuDataOut,
	// Tile RAM side
	input tilemapPkg::byteT ramDataIn,
	output tilemapPkg::byteT ramDataOut,
	output tilemapPkg::ramAddrT ramAddr,
	output logic ramWeN,
	output logic ramOeN,
	// Graphics ROM side
	output tilemapPkg::romAddrT romAddr,
	// Half-tile bits per layer
	output logic halfA,
	output logic halfB
);

	tilemapPkg::regWriteT regWriteA;
	tilemapPkg::regWriteT regWriteB;
	tilemapPkg::layerAddrT layerAddrA;
	tilemapPkg::layerAddrT layerAddrB;

	//////////////////////////////
	// Register strobe split
	//////////////////////////////

	// cpuAddr bit 2 picks the layer
	always_comb begin
		regWriteA.strobe = !latchN && !cpuAddr[2];
		regWriteA.sel = cpuAddr[1:0];
		regWriteA.data = cpuDataIn;
		regWriteB.strobe = !latchN && cpuAddr[2];
		regWriteB.sel = cpuAddr[1:0];
		regWriteB.data = cpuDataIn;
	end

	// Layer A fetches in the clk2H high phase
	scrollLayer #(
		.autoScroll(autoScrollA)
	) layerA (
		.CLK_6M(CLK_6M),
		.rstN(rstN),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.flip(flip),
		.fetchSlot(clk2H),
		.ramCsN(ramCsN),
		.regWrite(regWriteA),
		.ramData(ramDataIn),
		.addr(layerAddrA)
	);

	// Layer B fetches in the clk2H low phase
	scrollLayer #(
		.autoScroll(autoScrollB)
	) layerB (
		.CLK_6M(CLK_6M),
		.rstN(rstN),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.flip(flip),
		.fetchSlot(~clk2H),
		.ramCsN(ramCsN),
		.regWrite(regWriteB),
		.ramData(ramDataIn),
		.addr(layerAddrB)
	);

	cpuRamPort port (
		.CLK_6M(CLK_6M),
		.rstN(rstN),
		.clk2H(clk2H),
		.ramCsN(ramCsN),
		.readNotWrite(readNotWrite),
		.cpuAddr(cpuAddr),
		.cpuDataIn(cpuDataIn),
		.ramDataIn(ramDataIn),
		.layerA(layerAddrA),
		.layerB(layerAddrB),
		.ramAddr(ramAddr),
		.romAddr(romAddr),
		.ramWeN(ramWeN),
		.ramOeN(ramOeN),
		.cpuDataOut(cpuDataOut),
		.ramDataOut(ramDataOut)
	);

	// Half-tile bits straight from each layer
	assign halfA = layerAddrA.half;
	assign halfB = layerAddrB.half;

endmodule

// File: verif/tilemapClock.sv
module tilemapClock #(
	parameter int halfPeriod = 50,
	parameter int resetCycles = 5
) (
	output logic CLK_6M,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 100ps;

	// 100 ns period, starts low
	initial begin
		CLK_6M = 1'b0;
		forever begin
			#halfPeriod;
			CLK_6M = ~CLK_6M;
		end
	end

	// Released together with a falling edge, away from the flop edge
	initial begin
		rstN = 1'b0;
		#(resetCycles * 2 * halfPeriod);
		rstN = 1'b1;
	end

endmodule

// File: verif/tilemapTb.sv
module tilemapTb;
	timeunit 1ns;
	timeprecision 100ps;

	// Layer B scrolls one pixel per frame by itself
	localparam bit autoScrollA = 1'b0;
	localparam bit autoScrollB = 1'b1;
	// Poll limits in ns
	localparam int edgeTimeout = 200;
	localparam int resetTimeout = 2000;

	// One clock cycle of stimulus and the expected strobes
	typedef struct packed {
		logic clk2H;
		logic hSyncN;
		logic vSyncN;
		logic flip;
		logic latchN;
		logic ramCsN;
		logic readNotWrite;
		tilemapPkg::cpuAddrT cpuAddr;
		tilemapPkg::byteT cpuDataIn;
		tilemapPkg::byteT ramDataIn;
		logic expWeN;
		logic expOeN;
	} stepT;

	logic CLK_6M, rstN;
	logic clk2H, hSyncN, vSyncN, flip;
	logic latchN, ramCsN, readNotWrite;
	tilemapPkg::cpuAddrT cpuAddr;
	tilemapPkg::byteT cpuDataIn, cpuDataOut, ramDataIn, ramDataOut;
	tilemapPkg::ramAddrT ramAddr;
	tilemapPkg::romAddrT romAddr;
	logic ramWeN, ramOeN, halfA, halfB;

	// Stimulus table, row names, row under construction
	stepT steps[$];
	string stepNames[$];
	stepT row;

	// Beam counters and registers as the sync and CPU rules give them
	tilemapPkg::hPosT colModel;
	tilemapPkg::vPosT lineModel;
	logic hSyncLast, vSyncLast;
	tilemapPkg::scrollXT scrollXModel[2];
	tilemapPkg::scrollYT scrollYModel[2];
	tilemapPkg::byteT tileModel[2];

	tilemapClock clockGen (
		.CLK_6M(CLK_6M),
		.rstN(rstN)
	);

	tilemapAddrGen #(
		.autoScrollA(autoScrollA),
		.autoScrollB(autoScrollB)
	) u_dut (.*);

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic stopRun();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic checkRamAddr(input string name, input tilemapPkg::ramAddrT exp,
			input tilemapPkg::ramAddrT act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			stopRun();
		end
	endtask

	task automatic checkRomAddr(input string name, input tilemapPkg::romAddrT exp,
			input tilemapPkg::romAddrT act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			stopRun();
		end
	endtask

	task automatic checkByte(input string name, input tilemapPkg::byteT exp,
			input tilemapPkg::byteT act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			stopRun();
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			stopRun();
		end
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Addresses one layer should present now
	function automatic tilemapPkg::layerAddrT expectLayer(input int layer, input logic flipped);
		tilemapPkg::layerAddrT result;
		tilemapPkg::hPosT colVal;
		tilemapPkg::vPosT lineVal;
		// Sums wrap at 512 and 256
		colVal = colModel + scrollXModel[layer];
		lineVal = lineModel + scrollYModel[layer];
		if (flipped) begin
			colVal = ~colVal;
			lineVal = ~lineVal;
		end
		result.ram = {1'b0, lineVal[7:3], colVal[8:3]};
		result.rom = {tileModel[layer], lineVal[2:0], colVal[2:0]};
		result.half = colVal[2];
		return result;
	endfunction

	// State change at the rising edge that follows a row
	task automatic advanceModel(input stepT s);
		int target;
		int xTarget;
		target = s.cpuAddr[2] ? 1 : 0;
		// Layer whose X register the CPU writes now, or -1
		xTarget = -1;
		if (!s.latchN) begin
			case (s.cpuAddr[1:0])
				tilemapPkg::regXLo: begin
					scrollXModel[target][7:0] = s.cpuDataIn;
					xTarget = target;
				end
				tilemapPkg::regXHi: begin
					scrollXModel[target][8] = s.cpuDataIn[0];
					xTarget = target;
				end
				tilemapPkg::regY: scrollYModel[target] = s.cpuDataIn;
				default: ;
			endcase
		end
		// Frame start steps the autoscrolling layers unless the CPU writes X
		if (vSyncLast && !s.vSyncN) begin
			if (autoScrollA && xTarget != 0) begin
				scrollXModel[0] = scrollXModel[0] + 9'd1;
			end
			if (autoScrollB && xTarget != 1) begin
				scrollXModel[1] = scrollXModel[1] + 9'd1;
			end
		end
		// Fetch slots are lost while the CPU is on the bus
		if (s.ramCsN) begin
			if (s.clk2H) begin
				tileModel[0] = s.ramDataIn;
			end else begin
				tileModel[1] = s.ramDataIn;
			end
		end
		if (!s.vSyncN) begin
			lineModel = '0;
		end else if (hSyncLast && !s.hSyncN) begin
			lineModel = lineModel + 8'd1;
		end
		if (s.hSyncN) begin
			colModel = colModel + 9'd1;
		end else begin
			colModel = '0;
		end
		hSyncLast = s.hSyncN;
		vSyncLast = s.vSyncN;
	endtask

	task automatic checkStep(input string name, input stepT s);
		tilemapPkg::layerAddrT expA;
		tilemapPkg::layerAddrT expB;
		tilemapPkg::ramAddrT expRam;
		expA = expectLayer(0, s.flip);
		expB = expectLayer(1, s.flip);
		// CPU select owns the RAM bus over the 2H layer choice
		if (!s.ramCsN) begin
			expRam = s.cpuAddr[12:0];
		end else if (s.clk2H) begin
			expRam = {1'b0, expA.ram};
		end else begin
			expRam = {1'b1, expB.ram};
		end
		checkRamAddr({name, " ramAddr"}, expRam, ramAddr);
		// ROM bus serves the layer that just fetched
		checkRomAddr({name, " romAddr"}, s.clk2H ? expB.rom : expA.rom, romAddr);
		checkBit({name, " halfA"}, expA.half, halfA);
		checkBit({name, " halfB"}, expB.half, halfB);
		checkBit({name, " ramWeN"}, s.expWeN, ramWeN);
		checkBit({name, " ramOeN"}, s.expOeN, ramOeN);
		checkByte({name, " cpuDataOut"}, s.ramDataIn, cpuDataOut);
		checkByte({name, " ramDataOut"}, s.cpuDataIn, ramDataOut);
	endtask

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	task automatic pushStep(input string name, input logic weN, input logic oeN);
		row.expWeN = weN;
		row.expOeN = oeN;
		steps.push_back(row);
		stepNames.push_back(name);
		// 2H phase flips every cycle
		row.clk2H = ~row.clk2H;
	endtask

	task automatic buildTable();
		int n;
		row = '0;
		row.clk2H = 1'b1;
		row.hSyncN = 1'b1;
		row.vSyncN = 1'b1;
		row.latchN = 1'b1;
		row.ramCsN = 1'b1;
		row.readNotWrite = 1'b1;
		// Unscrolled layer A with tile code 0
		for (n = 0; n < 4; n++) begin
			pushStep("after reset", 1'b1, 1'b1);
		end
		// One horizontal sync steps the line count
		row.hSyncN = 1'b0;
		for (n = 0; n < 2; n++) begin
			pushStep("hsync", 1'b1, 1'b1);
		end
		row.hSyncN = 1'b1;
		// X low, X high, Y of layer A then layer B
		row.latchN = 1'b0;
		for (n = 0; n < 6; n++) begin
			row.cpuAddr = tilemapPkg::cpuAddrT'((n / 3) * 4 + (n % 3));
			row.cpuDataIn = tilemapPkg::byteT'($urandom);
			pushStep("scroll write", 1'b1, 1'b1);
		end
		row.latchN = 1'b1;
		for (n = 0; n < 6; n++) begin
			row.ramDataIn = tilemapPkg::byteT'($urandom);
			pushStep("scrolled", 1'b1, 1'b1);
		end
		row.flip = 1'b1;
		for (n = 0; n < 4; n++) begin
			row.ramDataIn = tilemapPkg::byteT'($urandom);
			pushStep("flipped", 1'b1, 1'b1);
		end
		row.flip = 1'b0;
		// B slot code shows on the ROM bus in the next high phase
		for (n = 0; n < 4; n++) begin
			row.ramDataIn = tilemapPkg::byteT'($urandom);
			pushStep("tile fetch", 1'b1, 1'b1);
		end
		row.ramCsN = 1'b0;
		for (n = 0; n < 2; n++) begin
			row.cpuAddr = tilemapPkg::cpuAddrT'($urandom);
			row.ramDataIn = tilemapPkg::byteT'($urandom);
			pushStep("cpu read", 1'b1, 1'b0);
		end
		// Write held three cycles with the strobe only in the first
		row.readNotWrite = 1'b0;
		for (n = 0; n < 3; n++) begin
			row.cpuDataIn = tilemapPkg::byteT'($urandom);
			pushStep("cpu write", n != 0, 1'b1);
		end
		row.ramCsN = 1'b1;
		row.readNotWrite = 1'b1;
		pushStep("write end", 1'b1, 1'b1);
		row.vSyncN = 1'b0;
		for (n = 0; n < 3; n++) begin
			pushStep("vsync", 1'b1, 1'b1);
		end
		row.vSyncN = 1'b1;
		for (n = 0; n < 6; n++) begin
			row.ramDataIn = tilemapPkg::byteT'($urandom);
			pushStep("after vsync", 1'b1, 1'b1);
		end
	endtask

	task automatic applyStep(input stepT s);
		clk2H = s.clk2H;
		hSyncN = s.hSyncN;
		vSyncN = s.vSyncN;
		flip = s.flip;
		latchN = s.latchN;
		ramCsN = s.ramCsN;
		readNotWrite = s.readNotWrite;
		cpuAddr = s.cpuAddr;
		cpuDataIn = s.cpuDataIn;
		ramDataIn = s.ramDataIn;
	endtask

	// Poll for the next falling clock edge
	task automatic nextFall();
		int waited;
		waited = 0;
		while (CLK_6M !== 1'b1 && waited < edgeTimeout) begin
			#1;
			waited++;
		end
		while (CLK_6M !== 1'b0 && waited < edgeTimeout) begin
			#1;
			waited++;
		end
		if (waited >= edgeTimeout) begin
			$display("Timeout: the clock stopped toggling");
			stopRun();
		end
	endtask

	initial begin
		int i;
		int waited;
		// Seed once for the whole run
		void'($urandom(50));
		buildTable();
		// Inputs start at the idle first row
		applyStep(steps[0]);
		colModel = '0;
		lineModel = '0;
		hSyncLast = 1'b1;
		vSyncLast = 1'b1;
		for (i = 0; i < 2; i++) begin
			scrollXModel[i] = '0;
			scrollYModel[i] = '0;
			tileModel[i] = '0;
		end
		waited = 0;
		while (rstN !== 1'b1 && waited < resetTimeout) begin
			#1;
			waited++;
		end
		if (rstN !== 1'b1) begin
			$display("Timeout: reset was never released");
			stopRun();
		end else begin
			// One row per cycle driven in the low phase
			for (i = 0; i < steps.size(); i++) begin
				applyStep(steps[i]);
				#10;
				checkStep(stepNames[i], steps[i]);
				advanceModel(steps[i]);
				nextFall();
			end
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// File: list.f
source/tilemapPkg.sv
source/scrollLayer.sv
source/cpuRamPort.sv
source/tilemapAddrGen.sv
verif/tilemapClock.sv
verif/tilemapTb.sv

// File: Bender.yml
package:
  name: tilemap_addr_gen

sources:
  # Design, package first
  - source/tilemapPkg.sv
  - source/scrollLayer.sv
  - source/cpuRamPort.sv
  - source/tilemapAddrGen.sv

  # Testbench
  - target: test
    files:
      - verif/tilemapClock.sv
      - verif/tilemapTb.sv
